// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// Address and instruction width
	localparam int ADDR_W = 32;

	// Fault and flag field returned with each instruction
	localparam int MMU_FLAGS_W = 12;

	// Lowest tag bit for the default 8 entry BTB
	localparam int BTB_TAG_LSB = 5;

	// PC sequencer states
	typedef enum logic [1:0] {
		RESET_START = 2'h0,
		FETCH       = 2'h1,
		WAIT_ADDR   = 2'h2
	} fetch_state_e;

	// Opcode field, instruction bits 30 to 21
	typedef enum logic [9:0] {
		OP_B   = 10'h0a0,   // Direct branch
		OP_BR  = 10'h0a1,   // Register indirect
		OP_BUR = 10'h0a2    // Unconditional register indirect
	} branch_op_e;

endpackage

`default_nettype wire

// File: verilog/fetch_if.sv
`default_nettype none
`timescale 1ns/10ps

// Search path between fetch and the BTB
interface predict_if;
	logic search_stb;
	logic [fetch_pkg::ADDR_W-1:0] search_addr;
	logic lock;
	logic valid;
	logic taken;
	logic [fetch_pkg::ADDR_W-1:0] target;

	modport fetcher (output search_stb, search_addr, lock, input valid, taken, target);
	modport predictor (input search_stb, search_addr, lock, output valid, taken, target);
endinterface

// Resolved branch results from execute
interface btb_update_if;
	logic stb;
	logic taken;
	logic [fetch_pkg::ADDR_W-1:0] target;
	logic [fetch_pkg::ADDR_W-1:0] inst_addr;

	modport source (output stb, taken, target, inst_addr);
	modport sink (input stb, taken, target, inst_addr);
endinterface

`default_nettype wire

// File: verilog/fetch_queue.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_queue #(
	parameter int WIDTH = 34,
	parameter int DEPTH = 8
)(
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input wire wr_en,
	input wire [WIDTH-1:0] wr_data,
	output wire full,
	input wire rd_en,
	output wire [WIDTH-1:0] rd_data
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign do_wr = wr_en && !full && !flush;
	assign do_rd = rd_en && (count != '0) && !flush;
	assign rd_data = mem[rd_ptr];   // Oldest entry shown ahead

	always_ff @(posedge iCLOCK) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush) begin   // Drop everything in flight
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
`default_nettype none
`timescale 1ns/10ps

module branch_predictor #(
	parameter int BTB_ENTRIES = 1 << (fetch_pkg::BTB_TAG_LSB - 2)
)(
	input wire iCLOCK,
	input wire inRESET,
	predict_if.predictor search,
	btb_update_if.sink update
);
	localparam int IDX_W = (BTB_ENTRIES > 1) ? $clog2(BTB_ENTRIES) : 1;
	localparam int TAG_LSB = IDX_W + 2;
	localparam int TAG_W = fetch_pkg::ADDR_W - TAG_LSB;

	logic [BTB_ENTRIES-1:0] entry_valid;
	logic [TAG_W-1:0] entry_tag [BTB_ENTRIES];
	logic [fetch_pkg::ADDR_W-1:0] entry_target [BTB_ENTRIES];

	logic [IDX_W-1:0] search_idx;
	logic [TAG_W-1:0] search_tag;
	logic search_hit;
	logic [IDX_W-1:0] upd_idx;
	logic [TAG_W-1:0] upd_tag;
	logic upd_match;

	// Tag | index | byte offset
	assign search_idx = search.search_addr[TAG_LSB-1:2];
	assign search_tag = search.search_addr[fetch_pkg::ADDR_W-1:TAG_LSB];
	assign search_hit = entry_valid[search_idx] && (entry_tag[search_idx] == search_tag);

	assign upd_idx = update.inst_addr[TAG_LSB-1:2];
	assign upd_tag = update.inst_addr[fetch_pkg::ADDR_W-1:TAG_LSB];
	assign upd_match = (entry_tag[upd_idx] == upd_tag);

	// Registered answer, frozen while decode stalls
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			search.valid <= 1'b0;
			search.taken <= 1'b0;
			search.target <= '0;
		end
		else if (!search.lock) begin
			search.valid <= search.search_stb;
			search.taken <= search.search_stb && search_hit;
			search.target <= search_hit ? entry_target[search_idx] : '0;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entry_valid <= '0;
		end
		else if (update.stb) begin
			if (update.taken) begin
				entry_valid[upd_idx] <= 1'b1;
			end
			else if (upd_match) begin   // Not taken any more, evict
				entry_valid[upd_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (update.stb && update.taken) begin
			entry_tag[upd_idx] <= upd_tag;
			entry_target[upd_idx] <= update.target;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_unit #(
	parameter logic [fetch_pkg::ADDR_W-1:0] RESET_VECTOR = '0,
	parameter int QUEUE_DEPTH = 8
)(
	input wire iCLOCK,
	input wire inRESET,
	input wire [31:0] psr,
	input wire exception_event,
	input wire exception_addr_set,
	input wire [fetch_pkg::ADDR_W-1:0] exception_addr,
	output wire fetch_req,
	output wire [fetch_pkg::ADDR_W-1:0] fetch_addr,
	input wire fetch_lock,
	input wire inst_valid,
	input wire [fetch_pkg::ADDR_W-1:0] inst,
	input wire [fetch_pkg::MMU_FLAGS_W-1:0] mmu_flags,
	predict_if.fetcher predict,
	output wire predict_flush,
	output wire next_inst_valid,
	output wire [fetch_pkg::ADDR_W-1:0] next_inst,
	output wire [fetch_pkg::MMU_FLAGS_W-1:0] next_mmu_flags,
	output wire next_paging_ena,
	output wire next_kernel_access,
	output wire [fetch_pkg::ADDR_W-1:0] next_pc,
	output wire next_branch_predict,
	output wire [fetch_pkg::ADDR_W-1:0] next_branch_predict_addr,
	input wire next_fetch_stop,
	input wire next_lock
);
	localparam int Q_W = fetch_pkg::ADDR_W + 2;

	fetch_pkg::fetch_state_e state;
	logic [fetch_pkg::ADDR_W-1:0] pc;
	logic req_ok;
	logic flush;
	logic inst_is_branch;
	logic queue_full;
	logic [Q_W-1:0] q_rd_data;
	logic [fetch_pkg::ADDR_W-1:0] q_addr;
	logic q_paging_ena;
	logic q_kernel_access;
	logic paging_ena;
	logic kernel_access;

	logic out_valid;
	logic [fetch_pkg::ADDR_W-1:0] out_inst;
	logic [fetch_pkg::MMU_FLAGS_W-1:0] out_mmu_flags;
	logic out_paging_ena;
	logic out_kernel_access;
	logic [fetch_pkg::ADDR_W-1:0] out_pc;

	assign paging_ena = psr[1] || psr[0];
	assign kernel_access = !(psr[6] || psr[5]);   // Not user mode

	assign flush = predict.valid && predict.taken && !next_lock && !exception_event;
	assign req_ok = (state == fetch_pkg::FETCH) && !fetch_lock && !queue_full
		&& !next_fetch_stop && !exception_event && !flush;

	assign fetch_req = req_ok;
	assign fetch_addr = pc;
	assign predict_flush = flush;

	// Address and privilege of each request in flight
	fetch_queue #(
		.WIDTH(Q_W),
		.DEPTH(QUEUE_DEPTH)
	) u_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(exception_event || flush),
		.wr_en(req_ok),
		.wr_data({kernel_access, paging_ena, pc}),
		.full(queue_full),
		.rd_en(inst_valid && !next_lock),
		.rd_data(q_rd_data)
	);

	assign {q_kernel_access, q_paging_ena, q_addr} = q_rd_data;

	always_comb begin
		case (inst[30:21])
			fetch_pkg::OP_B,
			fetch_pkg::OP_BR,
			fetch_pkg::OP_BUR: inst_is_branch = 1'b1;
			default: inst_is_branch = 1'b0;
		endcase
	end

	assign predict.search_stb = inst_valid && inst_is_branch && !next_lock
		&& !exception_event && !flush;
	assign predict.search_addr = q_addr;
	assign predict.lock = next_lock && !exception_event;   // Stale answer dropped on exception

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= fetch_pkg::RESET_START;
			pc <= '0;
		end
		else if (exception_addr_set) begin
			state <= fetch_pkg::FETCH;
			pc <= {exception_addr[fetch_pkg::ADDR_W-1:1], 1'b0};
		end
		else if (exception_event) begin
			state <= fetch_pkg::WAIT_ADDR;
		end
		else if (flush) begin   // Predicted taken, jump
			state <= fetch_pkg::FETCH;
			pc <= predict.target;
		end
		else begin
			case (state)
				fetch_pkg::RESET_START: begin
					state <= fetch_pkg::FETCH;
					pc <= RESET_VECTOR;
				end
				fetch_pkg::FETCH: begin
					if (req_ok) begin
						pc <= pc + 32'd4;
					end
				end
				default: state <= state;   // Parked until the new address arrives
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_valid <= 1'b0;
			out_inst <= '0;
			out_mmu_flags <= '0;
			out_paging_ena <= 1'b0;
			out_kernel_access <= 1'b0;
			out_pc <= '0;
		end
		else if (exception_event || flush) begin
			out_valid <= 1'b0;
			out_inst <= '0;
			out_mmu_flags <= '0;
			out_paging_ena <= 1'b0;
			out_kernel_access <= 1'b0;
			out_pc <= '0;
		end
		else if (!next_lock) begin
			out_valid <= inst_valid;
			out_inst <= inst;
			out_mmu_flags <= mmu_flags;
			out_paging_ena <= q_paging_ena;
			out_kernel_access <= q_kernel_access;
			out_pc <= q_addr + 32'd4;
		end
	end

	assign next_inst_valid = out_valid;
	assign next_inst = out_inst;
	assign next_mmu_flags = out_mmu_flags;
	assign next_paging_ena = out_paging_ena;
	assign next_kernel_access = out_kernel_access;
	assign next_pc = out_pc;
	assign next_branch_predict = predict.valid && predict.taken;
	assign next_branch_predict_addr = predict.target;

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_top #(
	parameter logic [fetch_pkg::ADDR_W-1:0] RESET_VECTOR = '0,
	parameter int QUEUE_DEPTH = 8,
	parameter int BTB_ENTRIES = 1 << (fetch_pkg::BTB_TAG_LSB - 2)
)(
	input wire iCLOCK,
	input wire inRESET,
	input wire [31:0] psr,
	input wire exception_event,
	input wire exception_addr_set,
	input wire [fetch_pkg::ADDR_W-1:0] exception_addr,
	output wire fetch_req,
	output wire [fetch_pkg::ADDR_W-1:0] fetch_addr,
	input wire fetch_lock,
	input wire inst_valid,
	input wire [fetch_pkg::ADDR_W-1:0] inst,
	input wire [fetch_pkg::MMU_FLAGS_W-1:0] mmu_flags,
	output wire prev_lock,
	output wire predict_flush,
	output wire next_inst_valid,
	output wire [fetch_pkg::ADDR_W-1:0] next_inst,
	output wire [fetch_pkg::MMU_FLAGS_W-1:0] next_mmu_flags,
	output wire next_paging_ena,
	output wire next_kernel_access,
	output wire [fetch_pkg::ADDR_W-1:0] next_pc,
	output wire next_branch_predict,
	output wire [fetch_pkg::ADDR_W-1:0] next_branch_predict_addr,
	input wire next_fetch_stop,
	input wire next_lock,
	input wire bp_update_stb,
	input wire bp_update_taken,
	input wire [fetch_pkg::ADDR_W-1:0] bp_update_target,
	input wire [fetch_pkg::ADDR_W-1:0] bp_update_inst_addr
);
	predict_if u_predict_if ();
	btb_update_if u_btb_update_if ();

	// Execute side results into the BTB
	assign u_btb_update_if.stb = bp_update_stb;
	assign u_btb_update_if.taken = bp_update_taken;
	assign u_btb_update_if.target = bp_update_target;
	assign u_btb_update_if.inst_addr = bp_update_inst_addr;

	assign prev_lock = next_lock;   // Memory holds its response during a stall

	fetch_unit #(
		.RESET_VECTOR(RESET_VECTOR),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_fetch_unit (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.psr(psr),
		.exception_event(exception_event),
		.exception_addr_set(exception_addr_set),
		.exception_addr(exception_addr),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.fetch_lock(fetch_lock),
		.inst_valid(inst_valid),
		.inst(inst),
		.mmu_flags(mmu_flags),
		.predict(u_predict_if.fetcher),
		.predict_flush(predict_flush),
		.next_inst_valid(next_inst_valid),
		.next_inst(next_inst),
		.next_mmu_flags(next_mmu_flags),
		.next_paging_ena(next_paging_ena),
		.next_kernel_access(next_kernel_access),
		.next_pc(next_pc),
		.next_branch_predict(next_branch_predict),
		.next_branch_predict_addr(next_branch_predict_addr),
		.next_fetch_stop(next_fetch_stop),
		.next_lock(next_lock)
	);

	branch_predictor #(
		.BTB_ENTRIES(BTB_ENTRIES)
	) u_branch_predictor (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.search(u_predict_if.predictor),
		.update(u_btb_update_if.sink)
	);

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
	output logic iCLOCK,
	output logic inRESET
);
	initial begin
		iCLOCK = 1'b0;
		forever #5 iCLOCK = ~iCLOCK;   // 10 ns period
	end

	initial begin
		inRESET = 1'b0;
		repeat (16) @(posedge iCLOCK);
		#1 inRESET = 1'b1;
	end
endmodule

`default_nettype wire

// File: sim/tb_fetch_top.sv
`default_nettype none
`timescale 1ns/10ps

module tb_fetch_top;
	localparam logic [31:0] RESET_VECTOR = 32'h100;
	localparam int CYCLE_LIMIT = 5000;

	wire iCLOCK;
	wire inRESET;
	logic [31:0] psr;
	logic exception_event, exception_addr_set;
	logic [31:0] exception_addr;
	wire fetch_req;
	wire [31:0] fetch_addr;
	logic fetch_lock, inst_valid;
	logic [31:0] inst;
	logic [11:0] mmu_flags;
	wire prev_lock, predict_flush, next_inst_valid;
	wire [31:0] next_inst;
	wire [11:0] next_mmu_flags;
	wire next_paging_ena, next_kernel_access;
	wire [31:0] next_pc;
	wire next_branch_predict;
	wire [31:0] next_branch_predict_addr;
	logic next_fetch_stop, next_lock;
	logic bp_update_stb, bp_update_taken;
	logic [31:0] bp_update_target, bp_update_inst_addr;

	logic [31:0] exp_addr_q[$];
	logic exp_paging_q[$];
	logic exp_kernel_q[$];
	logic [31:0] mem_addr_q[$];
	int mem_ready_q[$];
	logic [31:0] btb_tgt [logic [31:0]];   // Reference BTB contents
	logic [31:0] next_req_addr = RESET_VECTOR;
	logic [31:0] flush_target;
	logic waiting_addr = 1'b0;
	int mem_cyc = 0;
	int run_cyc = 0;
	int errors = 0;
	int checks = 0;
	int test_base = 0;
	int flushes = 0;
	int predicted = 0;

	tb_clock_gen u_clk (.iCLOCK(iCLOCK), .inRESET(inRESET));

	fetch_top #(
		.RESET_VECTOR(RESET_VECTOR),
		.QUEUE_DEPTH(8),
		.BTB_ENTRIES(8)
	) u_dut (.*);

	function automatic logic is_branch(input logic [31:0] a);
		return (a == 32'h140) || (a == 32'h1c4) || (a == 32'h200);
	endfunction

	// Branch words at a few fixed addresses, plain pattern elsewhere
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		if (is_branch(a)) begin
			return {1'b0, fetch_pkg::OP_B, a[20:0]};
		end
		return a ^ 32'h5a5a_0000;
	endfunction

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		errors++;
	endtask

	task automatic rule_error(input string msg);
		$display("Failure at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name);
		$display("%-32s errors %0d", name, errors - test_base);
		test_base = errors;
	endtask

	task automatic tick();
		@(posedge iCLOCK);
		#1;
	endtask

	// Memory model and scoreboard
	always @(posedge iCLOCK) begin
		logic [31:0] a;
		logic pg;
		logic kn;
		logic pred;
		if (inRESET) begin
			mem_cyc++;
			if (next_inst_valid && !next_lock && !exception_event) begin
				if (exp_addr_q.size() == 0) begin
					rule_error("instruction delivered with no request outstanding");
				end
				else begin
					a = exp_addr_q.pop_front();
					pg = exp_paging_q.pop_front();
					kn = exp_kernel_q.pop_front();
					pred = is_branch(a) && btb_tgt.exists(a);
					checks++;
					assert (next_inst == mem_word(a))
						else value_error("next_inst", next_inst, mem_word(a));
					assert (next_mmu_flags == a[11:0])
						else value_error("next_mmu_flags", next_mmu_flags, a[11:0]);
					assert (next_pc == a + 32'd4)
						else value_error("next_pc", next_pc, a + 32'd4);
					assert (next_paging_ena == pg)
						else value_error("next_paging_ena", next_paging_ena, pg);
					assert (next_kernel_access == kn)
						else value_error("next_kernel_access", next_kernel_access, kn);
					assert (next_branch_predict == pred)
						else value_error("next_branch_predict", next_branch_predict, pred);
					if (pred) begin
						predicted++;
						flush_target = btb_tgt[a];
						assert (next_branch_predict_addr == flush_target)
							else value_error("next_branch_predict_addr",
								next_branch_predict_addr, flush_target);
					end
				end
			end
			if (inst_valid && !next_lock && mem_addr_q.size() != 0) begin
				void'(mem_addr_q.pop_front());
				void'(mem_ready_q.pop_front());
			end
			if (fetch_req) begin
				checks++;
				assert (fetch_addr == next_req_addr)
					else value_error("fetch_addr", fetch_addr, next_req_addr);
				exp_addr_q.push_back(next_req_addr);
				exp_paging_q.push_back(psr[1:0] != 2'b00);
				exp_kernel_q.push_back(psr[6:5] == 2'b00);   // Neither user mode bit set
				mem_addr_q.push_back(fetch_addr);
				mem_ready_q.push_back(mem_cyc + $urandom_range(3, 1));
				next_req_addr = next_req_addr + 32'd4;
			end
			if (exception_event || predict_flush) begin   // Everything in flight is dropped
				exp_addr_q.delete();
				exp_paging_q.delete();
				exp_kernel_q.delete();
				mem_addr_q.delete();
				mem_ready_q.delete();
			end
			if (predict_flush) begin
				flushes++;
				next_req_addr = flush_target;
			end
			if (exception_event) waiting_addr = 1'b1;
			if (exception_addr_set) begin
				waiting_addr = 1'b0;
				next_req_addr = {exception_addr[31:1], 1'b0};
			end
		end
		#1;
		if (mem_addr_q.size() != 0 && mem_ready_q[0] <= mem_cyc) begin
			inst_valid = 1'b1;
			inst = mem_word(mem_addr_q[0]);
			mmu_flags = mem_addr_q[0][11:0];
		end
		else begin
			inst_valid = 1'b0;
		end
	end

	always @(posedge iCLOCK) begin
		run_cyc++;
		if (run_cyc >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	// One idle cycle after reset, then the first request
	assert property (@(posedge iCLOCK) $rose(inRESET)
		|-> (!fetch_req && !next_inst_valid && !next_branch_predict && !predict_flush)
		##1 (fetch_req || fetch_lock))
		else rule_error("outputs not idle after reset or first request late");
	assert property (@(posedge iCLOCK) disable iff (!inRESET) (next_lock && !exception_event)
		|=> ($stable(next_inst_valid) && $stable(next_inst) && $stable(next_mmu_flags)
		&& $stable(next_paging_ena) && $stable(next_kernel_access) && $stable(next_pc)
		&& $stable(next_branch_predict) && $stable(next_branch_predict_addr)))
		else rule_error("decode outputs changed while next_lock was high");
	assert property (@(posedge iCLOCK) prev_lock == next_lock)
		else value_error("prev_lock", prev_lock, next_lock);
	assert property (@(posedge iCLOCK) disable iff (!inRESET) next_fetch_stop |-> !fetch_req)
		else rule_error("fetch request made while next_fetch_stop was high");
	assert property (@(posedge iCLOCK) disable iff (!inRESET) waiting_addr |-> !fetch_req)
		else rule_error("fetch request made before exception_addr_set");
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		exception_event |=> !next_inst_valid)
		else rule_error("next_inst_valid stayed high after exception_event");
	assert property (@(posedge iCLOCK) disable iff (!inRESET) predict_flush
		|-> !fetch_req ##1 !next_inst_valid)
		else rule_error("request or instruction seen across a flush");
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(inst_valid && !next_lock && !exception_event && !predict_flush) |=> next_inst_valid)
		else rule_error("returned instruction did not reach decode one cycle later");

	task automatic drain();
		next_fetch_stop = 1'b1;
		while (exp_addr_q.size() != 0) tick();
	endtask

	task automatic restart_at(input logic [31:0] addr);
		exception_event = 1'b1;
		tick();
		exception_event = 1'b0;
		repeat (4) tick();
		next_fetch_stop = 1'b0;
		exception_addr = addr;
		exception_addr_set = 1'b1;
		tick();
		exception_addr_set = 1'b0;
	endtask

	task automatic btb_write(input logic [31:0] addr, input logic [31:0] tgt,
			input logic taken);
		bp_update_stb = 1'b1;
		bp_update_taken = taken;
		bp_update_inst_addr = addr;
		bp_update_target = tgt;
		if (taken) btb_tgt[addr] = tgt;
		else if (btb_tgt.exists(addr)) btb_tgt.delete(addr);
		tick();
		bp_update_stb = 1'b0;
	endtask

	initial begin
		int fl;
		int pr;
		void'($urandom(44641));
		psr = 32'h0;
		exception_event = 1'b0;
		exception_addr_set = 1'b0;
		exception_addr = 32'h0;
		fetch_lock = 1'b0;
		inst_valid = 1'b0;
		inst = 32'h0;
		mmu_flags = 12'h0;
		next_fetch_stop = 1'b0;
		next_lock = 1'b0;
		bp_update_stb = 1'b0;
		bp_update_taken = 1'b0;
		bp_update_target = 32'h0;
		bp_update_inst_addr = 32'h0;
		wait (inRESET);
		for (int i = 0; i < 80; i++) begin
			fetch_lock = ($urandom_range(3, 0) == 0);
			tick();
		end
		fetch_lock = 1'b0;
		end_test("1 sequential stream");
		for (int i = 0; i < 80; i++) begin
			next_lock = ($urandom_range(2, 0) == 0);
			next_fetch_stop = (i >= 30 && i < 42);   // Decode asks fetch to pause
			tick();
		end
		next_lock = 1'b0;
		next_fetch_stop = 1'b0;
		repeat (20) tick();
		end_test("2 decode stall and stop");
		restart_at(32'h181);
		repeat (40) tick();
		end_test("3 exception restart");
		drain();
		btb_write(32'h140, 32'h300, 1'b1);
		btb_write(32'h1c4, 32'h340, 1'b1);
		btb_write(32'h1c4, 32'h340, 1'b0);   // Clears the entry again
		fl = flushes;
		pr = predicted;
		restart_at(32'h130);
		repeat (40) tick();
		if (flushes == fl || predicted == pr) rule_error("taken branch at 140 was not predicted");
		drain();
		restart_at(32'h1b8);
		repeat (50) tick();
		end_test("4 branch prediction");
		for (int i = 0; i < 60; i++) begin
			psr = {25'h0, $urandom_range(3, 0) == 0, $urandom_range(1, 0) == 0, 3'h0,
				2'($urandom_range(3, 0))};
			fetch_lock = ($urandom_range(3, 0) == 0);
			next_lock = ($urandom_range(4, 0) == 0);
			tick();
		end
		fetch_lock = 1'b0;
		next_lock = 1'b0;
		drain();
		end_test("5 paging and kernel flags");
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end
		else begin
			$display("test failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

// File: compile.f
verilog/fetch_pkg.sv
verilog/fetch_if.sv
verilog/fetch_queue.sv
verilog/branch_predictor.sv
verilog/fetch_unit.sv
verilog/fetch_top.sv
sim/tb_clock_gen.sv
sim/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - verilog/fetch_pkg.sv
  - verilog/fetch_if.sv
  - verilog/fetch_queue.sv
  - verilog/branch_predictor.sv
  - verilog/fetch_unit.sv
  - verilog/fetch_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_fetch_top.sv
